/* cache_sys.f */
+incdir+logic
logic/mem_pkg.sv
logic/cache_pkg.sv
logic/cache_ctrl_if.sv
logic/mem_bus_if.sv
logic/cache_controller.sv
logic/cache_datapath.sv
logic/mem_arbiter.sv
logic/main_memory.sv
logic/cache_sys_top.sv
verif/tb_clock_gen.sv
verif/cache_sys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the cache_sys testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module cache_sys_tb \
    -f cache_sys.f \
    --Mdir obj_dir -o cache_sys_sim

./obj_dir/cache_sys_sim

/* verif/cache_sys_tb.sv */
`include "cache_params.svh"

module cache_sys_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;
    import cache_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int RAND_OPS   = 200;
    localparam int NUM_OPS    = 2 + 3 + 5 + 6 + 2 + RAND_OPS;   // tests 1 to 6

    typedef struct packed {
        logic      hit;
        mem_word_t data;
    } expect_t;

    logic      clk;
    logic      rst_n;
    logic      rd [2];          // index 0 is p0 and index 1 is p1
    logic      wr [2];
    mem_addr_t addr [2];
    mem_word_t data_in [2];
    mem_word_t data_out [2];
    logic      done [2];
    logic      stall [2];
    logic      hit [2];
    logic      err [2];

    // reference model state
    mem_word_t  ref_mem [`MEM_WORDS];
    cache_tag_t ref_tag [2][`CACHE_SETS][2];
    logic       ref_valid [2][`CACHE_SETS][2];
    cache_way_t ref_victim [2];
    expect_t    exp_q0 [$];
    expect_t    exp_q1 [$];
    logic [15:0] lfsr_state = 16'd42;

    tb_clock_gen #(.PERIOD_NS(CLK_PERIOD)) clk_gen_i (.clk(clk));

    cache_sys_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .p0_rd        (rd[0]),
        .p0_wr        (wr[0]),
        .p0_addr      (addr[0]),
        .p0_data_in   (data_in[0]),
        .p0_data_out  (data_out[0]),
        .p0_done      (done[0]),
        .p0_stall     (stall[0]),
        .p0_cache_hit (hit[0]),
        .p0_err       (err[0]),
        .p1_rd        (rd[1]),
        .p1_wr        (wr[1]),
        .p1_addr      (addr[1]),
        .p1_data_in   (data_in[1]),
        .p1_data_out  (data_out[1]),
        .p1_done      (done[1]),
        .p1_stall     (stall[1]),
        .p1_cache_hit (hit[1]),
        .p1_err       (err[1])
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {lfsr_state[14:0],
                          lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10]};
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // 4 tags into sets 0 to 3 of the port's address half
    function automatic mem_addr_t rand_addr(input logic port);
        logic [15:0] t;
        logic [15:0] s;
        logic [15:0] w;
        t = rand_bits(2);
        s = rand_bits(2);
        w = rand_bits(2);
        return {port, 7'd0, t[1:0], 1'b0, s[1:0], w[1:0], 1'b0};
    endfunction

    function automatic expect_t ref_access(input logic port, input logic is_wr,
                                           input mem_addr_t a, input mem_word_t wd);
        cache_index_t idx;
        cache_tag_t   tag;
        cache_way_t   way;
        expect_t      e;
        idx   = a[5:3];
        tag   = a[15:6];
        e.hit = 1'b1;
        if (ref_valid[port][idx][0] && ref_tag[port][idx][0] == tag) way = 1'b0;
        else if (ref_valid[port][idx][1] && ref_tag[port][idx][1] == tag) way = 1'b1;
        else begin
            e.hit = 1'b0;
            if (!ref_valid[port][idx][0]) way = 1'b0;      // invalid way first
            else if (!ref_valid[port][idx][1]) way = 1'b1;
            else way = ref_victim[port];
            ref_tag[port][idx][way]   = tag;
            ref_valid[port][idx][way] = 1'b1;
        end
        ref_victim[port] = ~ref_victim[port];   // pointer moves on every lookup
        if (is_wr) ref_mem[a[15:1]] = wd;
        e.data = ref_mem[a[15:1]];
        return e;
    endfunction

    task automatic check_word(input string name, input mem_word_t act, input mem_word_t exp);
        if (act !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, act, exp);
            $display("Something failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, act, exp);
            $display("Something failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic compare_result(input logic port, input mem_word_t data, input logic h);
        expect_t e;
        int      left;
        left = port ? exp_q1.size() : exp_q0.size();
        if (left == 0) begin
            $display("Port %0d raised done with no access outstanding", port);
            $display("Something failed");
            $fatal(1, "unexpected done");
        end else begin
            if (port) e = exp_q1.pop_front();
            else e = exp_q0.pop_front();
            check_word($sformatf("p%0d_data_out", port), data, e.data);
            check_flag($sformatf("p%0d_cache_hit", port), h, e.hit);
        end
    endtask

    // one processor access with inputs held until done
    task automatic run_access(input logic port, input logic is_wr, input mem_addr_t a,
                              input mem_word_t wd);
        expect_t e;
        e = ref_access(port, is_wr, a, wd);
        @(negedge clk);
        if (port) exp_q1.push_back(e);
        else exp_q0.push_back(e);
        rd[port]      = ~is_wr;
        wr[port]      = is_wr;
        addr[port]    = a;
        data_in[port] = wd;
        do begin
            @(negedge clk);
        end while (!done[port]);
        rd[port] = 1'b0;    // dropped before the edge that leaves the done state
        wr[port] = 1'b0;
    endtask

    always @(negedge clk) begin
        if (rst_n && done[0]) compare_result(1'b0, data_out[0], hit[0]);
        if (rst_n && done[1]) compare_result(1'b1, data_out[1], hit[1]);
    end

    initial begin
        #(NUM_OPS * 40 * CLK_PERIOD);
        $display("Timeout: the accesses did not finish within %0d ns", NUM_OPS * 40 * CLK_PERIOD);
        $display("Something failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        logic [15:0] rnd;
        logic        is_wr;
        for (int p = 0; p < 2; p++) begin
            rd[p]         = 1'b0;
            wr[p]         = 1'b0;
            addr[p]       = '0;
            data_in[p]    = '0;
            ref_victim[p] = 1'b0;
            for (int s = 0; s < `CACHE_SETS; s++) begin
                ref_valid[p][s][0] = 1'b0;
                ref_valid[p][s][1] = 1'b0;
            end
        end
        for (int i = 0; i < `MEM_WORDS; i++) ref_mem[i] = '0;
        rst_n = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        for (int p = 0; p < 2; p++) begin
            check_flag($sformatf("p%0d_done", p), done[p], 1'b0);
            check_flag($sformatf("p%0d_err", p), err[p], 1'b0);
            check_flag($sformatf("p%0d_stall", p), stall[p], 1'b0);
        end

        run_access(1'b0, 1'b0, 16'h0010, '0);               // fresh line misses
        run_access(1'b0, 1'b0, 16'h0016, '0);
        run_access(1'b0, 1'b1, 16'h0102, 16'hbeef);         // write allocate
        run_access(1'b0, 1'b0, 16'h0102, '0);
        run_access(1'b0, 1'b0, 16'h0106, '0);

        // tags 1 to 3 in set 5 where the hit read steers the victim onto tag 1
        run_access(1'b0, 1'b1, 16'h0068, 16'haaaa);
        run_access(1'b0, 1'b1, 16'h00a8, 16'hbbbb);
        run_access(1'b0, 1'b0, 16'h0068, '0);
        run_access(1'b0, 1'b1, 16'h00e8, 16'hcccc);
        run_access(1'b0, 1'b0, 16'h0068, '0);               // refilled after write-back

        fork
            run_access(1'b0, 1'b1, 16'h0230, 16'h1234);
            run_access(1'b1, 1'b1, 16'h8230, 16'h5678);
        join
        fork
            run_access(1'b0, 1'b0, 16'h0400, '0);
            run_access(1'b1, 1'b0, 16'h8400, '0);
        join
        fork
            run_access(1'b0, 1'b0, 16'h0230, '0);
            run_access(1'b1, 1'b0, 16'h8230, '0);
        join

        @(negedge clk);
        rd[0]   = 1'b1;     // rd and wr together
        wr[0]   = 1'b1;
        addr[0] = 16'h0010;
        @(negedge clk);
        check_flag("p0_err", err[0], 1'b1);
        check_flag("p0_done", done[0], 1'b0);
        rd[0] = 1'b0;
        wr[0] = 1'b0;
        @(negedge clk);
        check_flag("p0_err", err[0], 1'b0);
        run_access(1'b0, 1'b0, 16'h0010, '0);

        for (int i = 0; i < RAND_OPS; i++) begin
            rnd   = rand_bits(1);
            is_wr = rnd[0];
            run_access(i[0], is_wr, rand_addr(i[0]), rand_bits(16));
        end

        @(negedge clk);
        $display("Everything OK");
        $finish;
    end

endmodule

/* verif/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;

    always #(PERIOD_NS / 2) clk = ~clk;    // 50 % duty

endmodule

/* logic/cache_sys_top.sv */
module cache_sys_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               p0_rd,
    input  logic               p0_wr,
    input  mem_pkg::mem_addr_t p0_addr,
    input  mem_pkg::mem_word_t p0_data_in,
    output mem_pkg::mem_word_t p0_data_out,
    output logic               p0_done,
    output logic               p0_stall,
    output logic               p0_cache_hit,
    output logic               p0_err,
    input  logic               p1_rd,
    input  logic               p1_wr,
    input  mem_pkg::mem_addr_t p1_addr,
    input  mem_pkg::mem_word_t p1_data_in,
    output mem_pkg::mem_word_t p1_data_out,
    output logic               p1_done,
    output logic               p1_stall,
    output logic               p1_cache_hit,
    output logic               p1_err
);
    cache_ctrl_if c0_ctrl ();
    cache_ctrl_if c1_ctrl ();
    mem_bus_if    c0_bus ();
    mem_bus_if    c1_bus ();
    mem_bus_if    mem_bus ();     // arbiter to memory

    cache_controller u_ctrl0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (p0_rd),
        .wr        (p0_wr),
        .ctrl      (c0_ctrl),
        .cache_hit (p0_cache_hit),
        .stall_out (p0_stall),
        .done      (p0_done),
        .err       (p0_err)
    );

    cache_datapath u_dp0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (p0_addr),
        .data_in  (p0_data_in),
        .data_out (p0_data_out),
        .dp       (c0_ctrl),
        .mem      (c0_bus)
    );

    cache_controller u_ctrl1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (p1_rd),
        .wr        (p1_wr),
        .ctrl      (c1_ctrl),
        .cache_hit (p1_cache_hit),
        .stall_out (p1_stall),
        .done      (p1_done),
        .err       (p1_err)
    );

    cache_datapath u_dp1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .addr     (p1_addr),
        .data_in  (p1_data_in),
        .data_out (p1_data_out),
        .dp       (c1_ctrl),
        .mem      (c1_bus)
    );

    mem_arbiter u_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .port0 (c0_bus),
        .port1 (c1_bus),
        .mem   (mem_bus)
    );

    main_memory u_mem (
        .clk (clk),
        .bus (mem_bus)
    );

endmodule

/* logic/main_memory.sv */
`include "cache_params.svh"

module main_memory (
    input  logic      clk,
    mem_bus_if.server bus
);
    import mem_pkg::*;

    mem_word_t mem_q [`MEM_WORDS];
    mem_word_t rd_q1;
    mem_word_t rd_q2;

    initial begin
        for (int i = 0; i < `MEM_WORDS; i++) begin
            mem_q[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.wr) begin
            mem_q[bus.addr[`ADDR_W-1:1]] <= bus.wdata;  // word address
        end
        if (bus.rd) begin
            rd_q1 <= mem_q[bus.addr[`ADDR_W-1:1]];
        end
        rd_q2 <= rd_q1;
    end

    assign bus.rdata = rd_q2;   // two cycles after the accepting edge
    assign bus.stall = 1'b0;    // one word per cycle, never busy

endmodule

/* logic/mem_arbiter.sv */
module mem_arbiter (
    input  logic       clk,
    input  logic       rst_n,
    mem_bus_if.server  port0,
    mem_bus_if.server  port1,
    mem_bus_if.client  mem
);
    logic req0;
    logic req1;
    logic busy;
    logic gnt;          // 0: port0, 1: port1
    logic owner_vld;
    logic owner_id;
    logic last_win;

    assign req0 = port0.rd | port0.wr;
    assign req1 = port1.rd | port1.wr;
    assign busy = owner_vld & (owner_id ? req1 : req0);    // burst lock

    always_comb begin
        if (busy)             gnt = owner_id;
        else if (req0 & req1) gnt = ~last_win;
        else                  gnt = req1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_vld <= 1'b0;
            owner_id  <= 1'b0;
            last_win  <= 1'b1;  // port0 wins the first tie
        end else begin
            owner_vld <= gnt ? req1 : req0;
            owner_id  <= gnt;
            if (!busy && (req0 || req1)) last_win <= gnt;
        end
    end

    assign mem.rd    = gnt ? port1.rd    : port0.rd;
    assign mem.wr    = gnt ? port1.wr    : port0.wr;
    assign mem.addr  = gnt ? port1.addr  : port0.addr;
    assign mem.wdata = gnt ? port1.wdata : port0.wdata;

    assign port0.stall = req0 & (gnt | mem.stall);
    assign port1.stall = req1 & (~gnt | mem.stall);
    assign port0.rdata = mem.rdata;     // broadcast, owner tracks its own timing
    assign port1.rdata = mem.rdata;

endmodule

/* logic/cache_datapath.sv */
`include "cache_params.svh"

module cache_datapath (
    input  logic               clk,
    input  logic               rst_n,
    input  mem_pkg::mem_addr_t addr,
    input  mem_pkg::mem_word_t data_in,
    output mem_pkg::mem_word_t data_out,
    cache_ctrl_if.dp           dp,
    mem_bus_if.client          mem
);
    import mem_pkg::*;
    import cache_pkg::*;

    mem_word_t    data_mem [2][`CACHE_SETS][4];
    cache_tag_t   tag_mem  [2][`CACHE_SETS];
    logic [1:0]   valid_q  [`CACHE_SETS];   // bit per way
    logic [1:0]   dirty_q  [`CACHE_SETS];
    cache_way_t   victim_q;                 // one pointer for the whole cache
    cache_way_t   acc_way_q;                // way chosen in compare

    cache_index_t idx;
    cache_tag_t   tag;
    logic [1:0]   hit_way;
    logic         lookup;
    logic         we;
    cache_way_t   sel_way;
    cache_way_t   way;
    mem_offset_t  off;
    mem_word_t    wr_word;

    assign idx     = addr[INDEX_W+2:3];
    assign tag     = addr[`ADDR_W-1:INDEX_W+3];
    assign hit_way = {valid_q[idx][1] & (tag_mem[1][idx] == tag),
                      valid_q[idx][0] & (tag_mem[0][idx] == tag)};

    // hit way, else first invalid way, else the victim pointer
    always_comb begin
        if (hit_way[0])            sel_way = 1'b0;
        else if (hit_way[1])       sel_way = 1'b1;
        else if (!valid_q[idx][0]) sel_way = 1'b0;
        else if (!valid_q[idx][1]) sel_way = 1'b1;
        else                       sel_way = victim_q;
    end

    assign lookup  = dp.comp & ~dp.valid_in;    // compare state but not ALLOC_6
    assign way     = lookup ? sel_way : acc_way_q;
    assign off     = dp.cache_offset_select ? dp.cache_offset : addr[2:0];
    assign wr_word = dp.cache_data_in_select ? mem.rdata : data_in;
    assign we      = dp.cache_write & (~lookup | (|hit_way));

    assign dp.hit       = |hit_way;
    assign dp.valid     = valid_q[idx][way];
    assign dp.dirty     = dirty_q[idx][way];
    assign dp.mem_stall = mem.stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_q  <= 1'b0;
            acc_way_q <= 1'b0;
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s] <= 2'b00;
                dirty_q[s] <= 2'b00;
            end
        end else begin
            if (dp.flip_victimway) victim_q <= ~victim_q;
            if (lookup) acc_way_q <= sel_way;
            if (we) begin
                dirty_q[idx][way] <= dp.comp;   // cpu writes set dirty and fills clear it
                if (dp.valid_in) valid_q[idx][way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            data_mem[way][idx][off[2:1]] <= wr_word;
            if (dp.valid_in) tag_mem[way][idx] <= tag;
        end
    end

    assign data_out  = data_mem[way][idx][addr[2:1]];
    assign mem.rd    = dp.mem_rd;
    assign mem.wr    = dp.mem_wr;
    assign mem.addr  = {dp.tag_select ? tag_mem[acc_way_q][idx] : tag, idx, dp.mem_offset};
    assign mem.wdata = data_mem[acc_way_q][idx][dp.cache_offset[2:1]];   // write-back source

endmodule

/* logic/cache_controller.sv */
module cache_controller (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rd,
    input  logic      wr,
    cache_ctrl_if.ctrl ctrl,
    output logic      cache_hit,
    output logic      stall_out,
    output logic      done,
    output logic      err
);
    import cache_pkg::*;

    cache_state_t state;
    cache_state_t next_state;
    cache_state_t req_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // decode of a new processor request, shared by idle and both done states
    assign req_state = (rd & wr) ? ERROR      :
                       rd        ? COMPARE_RD :
                       wr        ? COMPARE_WR :
                                   IDLE;

    always_comb begin
        ctrl.comp                 = 1'b0;
        ctrl.cache_write          = 1'b0;
        ctrl.cache_offset         = 3'd0;
        ctrl.cache_offset_select  = 1'b0;
        ctrl.cache_data_in_select = 1'b0;
        ctrl.tag_select           = 1'b0;
        ctrl.valid_in             = 1'b0;
        ctrl.mem_rd               = 1'b0;
        ctrl.mem_wr               = 1'b0;
        ctrl.mem_offset           = 3'd0;
        ctrl.flip_victimway       = 1'b0;
        cache_hit                 = 1'b0;
        stall_out                 = 1'b1;   // busy unless idle or done
        done                      = 1'b0;
        err                       = 1'b0;
        next_state                = IDLE;

        case (state)
            IDLE: begin
                stall_out  = 1'b0;
                next_state = req_state;
            end
            COMPARE_RD, COMPARE_WR: begin
                ctrl.comp           = 1'b1;
                ctrl.cache_write    = (state == COMPARE_WR);
                ctrl.flip_victimway = 1'b1;
                next_state = (ctrl.hit & ctrl.valid)   ? HIT_DONE :
                             (ctrl.valid & ctrl.dirty) ? WB_0     :
                                                         ALLOC_0;
            end
            ALLOC_0: begin
                ctrl.mem_rd = 1'b1;
                next_state  = ctrl.mem_stall ? ALLOC_0 : ALLOC_1;   // wait for grant
            end
            ALLOC_1, ALLOC_2, ALLOC_3: begin
                ctrl.mem_rd     = 1'b1;
                ctrl.mem_offset = (state == ALLOC_1) ? 3'd2 : (state == ALLOC_2) ? 3'd4 : 3'd6;
                next_state      = cache_state_t'(state + 5'd1);
            end
            ALLOC_4: next_state = ALLOC_5;
            ALLOC_5: next_state = (wr & ~rd) ? ALLOC_6 : (rd & ~wr) ? MISS_DONE : ERROR;
            ALLOC_6: begin
                ctrl.comp        = 1'b1;    // merge cpu word, marks line dirty
                ctrl.cache_write = 1'b1;
                ctrl.valid_in    = 1'b1;
                next_state       = MISS_DONE;
            end
            WB_0, WB_1, WB_2, WB_3: begin
                ctrl.mem_wr              = 1'b1;
                ctrl.tag_select          = 1'b1;
                ctrl.cache_offset_select = 1'b1;
                ctrl.mem_offset          = {state[1:0] - 2'd2, 1'b0};   // WB_0 is 5'h0a
                ctrl.cache_offset        = ctrl.mem_offset;
                if (state == WB_0 && ctrl.mem_stall) begin
                    next_state = WB_0;
                end else begin
                    next_state = (state == WB_3) ? ALLOC_0 : cache_state_t'(state + 5'd1);
                end
            end
            HIT_DONE, MISS_DONE: begin
                done       = 1'b1;
                cache_hit  = (state == HIT_DONE);
                stall_out  = 1'b0;
                next_state = req_state;     // a held request goes straight back to compare
            end
            ERROR: begin
                err        = 1'b1;
                next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase

        // fill writes trail the memory reads by two states
        if (state inside {ALLOC_2, ALLOC_3, ALLOC_4, ALLOC_5}) begin
            ctrl.cache_write          = 1'b1;
            ctrl.valid_in             = 1'b1;
            ctrl.cache_offset_select  = 1'b1;
            ctrl.cache_data_in_select = 1'b1;
            ctrl.cache_offset         = {state[1:0] - 2'd1, 1'b0};  // ALLOC_2 is 5'h05
        end
    end

endmodule

/* logic/mem_bus_if.sv */
interface mem_bus_if;
    import mem_pkg::*;

    logic      rd;
    logic      wr;
    mem_addr_t addr;
    mem_word_t wdata;
    mem_word_t rdata;   // valid two cycles after an accepted read
    logic      stall;   // access accepted only when low

    modport client (
        output rd, wr, addr, wdata,
        input  rdata, stall
    );

    modport server (
        input  rd, wr, addr, wdata,
        output rdata, stall
    );
endinterface

/* logic/cache_ctrl_if.sv */
interface cache_ctrl_if;
    import mem_pkg::*;

    logic        comp;                  // lookup mode, write only on hit
    logic        cache_write;
    mem_offset_t cache_offset;
    logic        cache_offset_select;   // 1: offset from controller
    logic        cache_data_in_select;  // 1: fill from memory rdata
    logic        tag_select;            // 1: stored tag for write-back
    logic        valid_in;
    logic        mem_rd;
    logic        mem_wr;
    mem_offset_t mem_offset;
    logic        flip_victimway;
    logic        hit;
    logic        valid;
    logic        dirty;
    logic        mem_stall;

    modport ctrl (
        output comp, cache_write, cache_offset, cache_offset_select, cache_data_in_select,
        output tag_select, valid_in, mem_rd, mem_wr, mem_offset, flip_victimway,
        input  hit, valid, dirty, mem_stall
    );

    modport dp (
        input  comp, cache_write, cache_offset, cache_offset_select, cache_data_in_select,
        input  tag_select, valid_in, mem_rd, mem_wr, mem_offset, flip_victimway,
        output hit, valid, dirty, mem_stall
    );
endinterface

/* logic/cache_pkg.sv */
`include "cache_params.svh"

package cache_pkg;

    localparam int INDEX_W = $clog2(`CACHE_SETS);
    localparam int TAG_W   = `ADDR_W - INDEX_W - 3;  // 3 offset bits below the index

    typedef enum logic [4:0] {
        IDLE       = 5'h00,
        COMPARE_RD = 5'h01,
        COMPARE_WR = 5'h02,
        ALLOC_0    = 5'h03,
        ALLOC_1    = 5'h04,
        ALLOC_2    = 5'h05,
        ALLOC_3    = 5'h06,
        ALLOC_4    = 5'h07,
        ALLOC_5    = 5'h08,
        ALLOC_6    = 5'h09,
        WB_0       = 5'h0a,
        WB_1       = 5'h0b,
        WB_2       = 5'h0c,
        WB_3       = 5'h0d,
        HIT_DONE   = 5'h0e,
        MISS_DONE  = 5'h0f,
        ERROR      = 5'h10
    } cache_state_t;

    typedef logic [INDEX_W-1:0] cache_index_t;
    typedef logic [TAG_W-1:0]   cache_tag_t;
    typedef logic               cache_way_t;

endpackage

/* logic/mem_pkg.sv */
`include "cache_params.svh"

package mem_pkg;

    localparam int OFFSET_W = 3;    // byte offset inside a 4-word line

    typedef logic [`ADDR_W-1:0] mem_addr_t;
    typedef logic [`WORD_W-1:0] mem_word_t;

    // only 0, 2, 4 and 6 occur, words are aligned
    typedef logic [OFFSET_W-1:0] mem_offset_t;

endpackage

/* logic/cache_params.svh */
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

`define CACHE_SETS 8        // sets per cache, 2 ways each
`define MEM_WORDS  32768    // main memory depth in words
`define WORD_W     16       // processor word
`define ADDR_W     16       // byte address

`endif
